// File: logic/vldu.sv
/*
 * Vector load unit top level
 * Instruction queue, beat packer and lane writeback
 */
`timescale 1ns/1ns
`default_nettype none

module vldu import vldu_pkg::*; #(
  parameter int unsigned NR_LANES   = vldu_pkg::NR_LANES,
  parameter int unsigned INSN_DEPTH = 4,
  parameter int unsigned RESQ_DEPTH = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Sequencer
  input  logic                                  insn_valid_i,
  input  vldu_insn_t                            insn_i,
  output logic                                  insn_ready_o,
  input  logic [NR_VINSN-1:0]                   vinsn_running_i,
  // Memory read stream
  input  logic                                  r_valid_i,
  input  logic [BEAT_BYTES*8-1:0]               r_data_i,
  output logic                                  r_ready_o,
  // Lanes
  output logic [NR_LANES-1:0]                   lane_req_o,
  output logic [NR_LANES-1:0][VADDR_W-1:0]      lane_addr_o,
  output logic [NR_LANES-1:0][VID_W-1:0]        lane_id_o,
  output logic [NR_LANES-1:0][ELEN_BYTES*8-1:0] lane_wdata_o,
  output logic [NR_LANES-1:0][ELEN_BYTES-1:0]   lane_be_o,
  input  logic [NR_LANES-1:0]                   lane_gnt_i,
  // Completion
  output logic                                  done_valid_o,
  output logic [VID_W-1:0]                      done_id_o
);

  vldu_insn_t issue_insn, commit_insn;
  logic       issue_valid, issue_done;
  logic       commit_valid, commit_done;
  // Packer to result queue
  logic                                  push, full;
  logic [NR_LANES-1:0][ELEN_BYTES*8-1:0] word_wdata;
  logic [NR_LANES-1:0][ELEN_BYTES-1:0]   word_be;
  logic [VADDR_W-1:0]                    word_addr;
  logic [VID_W-1:0]                      word_id;

  vldu_insn_queue #(.DEPTH(INSN_DEPTH)) u_insn_queue (
    .clk_i, .rst_ni,
    .insn_valid_i, .insn_i, .insn_ready_o, .vinsn_running_i,
    .issue_insn_o(issue_insn), .issue_valid_o(issue_valid), .issue_done_i(issue_done),
    .commit_insn_o(commit_insn), .commit_valid_o(commit_valid), .commit_done_i(commit_done)
  );

  vldu_beat_packer #(.NR_LANES(NR_LANES)) u_beat_packer (
    .clk_i, .rst_ni,
    .issue_insn_i(issue_insn), .issue_valid_i(issue_valid), .issue_done_o(issue_done),
    .r_valid_i, .r_data_i, .r_ready_o,
    .full_i(full), .push_o(push),
    .word_wdata_o(word_wdata), .word_be_o(word_be),
    .word_addr_o(word_addr), .word_id_o(word_id)
  );

  vldu_writeback #(.NR_LANES(NR_LANES), .DEPTH(RESQ_DEPTH)) u_writeback (
    .clk_i, .rst_ni,
    .push_i(push), .word_wdata_i(word_wdata), .word_be_i(word_be),
    .word_addr_i(word_addr), .word_id_i(word_id), .full_o(full),
    .commit_insn_i(commit_insn), .commit_valid_i(commit_valid), .commit_done_o(commit_done),
    .lane_req_o, .lane_addr_o, .lane_id_o, .lane_wdata_o, .lane_be_o, .lane_gnt_i,
    .done_valid_o, .done_id_o
  );

endmodule

`default_nettype wire

// File: logic/vldu_beat_packer.sv
/*
 * Read beat packer that scatters beat bytes into VRF words
 * Byte enables and lane word address per pushed word
 */
`timescale 1ns/1ns
`default_nettype none

module vldu_beat_packer import vldu_pkg::*; #(
  parameter int unsigned NR_LANES = vldu_pkg::NR_LANES
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Instruction in issue phase
  input  vldu_insn_t                             issue_insn_i,
  input  logic                                   issue_valid_i,
  output logic                                   issue_done_o,
  // Memory read beats
  input  logic                                   r_valid_i,
  input  logic [BEAT_BYTES*8-1:0]                r_data_i,
  output logic                                   r_ready_o,
  // Result queue
  input  logic                                   full_i,
  output logic                                   push_o,
  output logic [NR_LANES-1:0][ELEN_BYTES*8-1:0]  word_wdata_o,
  output logic [NR_LANES-1:0][ELEN_BYTES-1:0]    word_be_o,
  output logic [VADDR_W-1:0]                     word_addr_o,
  output logic [VID_W-1:0]                       word_id_o
);

  localparam int unsigned WORD_BYTES = NR_LANES * ELEN_BYTES;
  localparam int unsigned WPNT_W     = $clog2(WORD_BYTES + 1);

  // Remaining bytes of the issuing instruction
  logic [INSN_BYTES_W-1:0] rem_q, rem;
  logic                    loaded_q;
  // Byte pointer in the word under construction
  logic [WPNT_W-1:0]       word_pnt_q;
  // Word sequence number within the instruction
  logic [VADDR_W-1:0]      seq_q;

  logic [NR_LANES-1:0][ELEN_BYTES*8-1:0] wdata_q, wdata_d;
  logic [NR_LANES-1:0][ELEN_BYTES-1:0]   be_q, be_d;

  logic [INSN_BYTES_W-1:0] beat_bytes;
  logic [INSN_BYTES_W-1:0] word_fill;
  logic                    take;
  logic                    last_beat;

  // First cycle of an instruction reads its size straight from the queue
  assign rem = loaded_q ? rem_q : insn_bytes(issue_insn_i);

  // Beats are packed, so only the tail of an instruction is short
  assign beat_bytes = (rem < INSN_BYTES_W'(BEAT_BYTES)) ? rem : INSN_BYTES_W'(BEAT_BYTES);
  assign word_fill  = INSN_BYTES_W'(word_pnt_q) + beat_bytes;

  // Word size is a multiple of the beat so every taken beat is used up
  assign r_ready_o = issue_valid_i && !full_i;
  assign take      = r_valid_i && r_ready_o;
  assign last_beat = (rem == beat_bytes);

  assign issue_done_o = take && last_beat;
  assign push_o       = take && (last_beat || word_fill == INSN_BYTES_W'(WORD_BYTES));

  ////////////////////////////////////////////////////
  // Byte scatter
  ////////////////////////////////////////////////////

  always_comb begin
    int unsigned b;
    int unsigned ln;
    int unsigned off;
    wdata_d = wdata_q;
    be_d    = be_q;
    for (int unsigned i = 0; i < BEAT_BYTES; i++) begin
      // Sequential byte in the VRF word and its shuffled position
      b   = word_pnt_q + i;
      ln  = shuffle_lane(b, issue_insn_i.vsew, NR_LANES);
      off = shuffle_offset(b, issue_insn_i.vsew, NR_LANES);
      if (i < beat_bytes) begin
        wdata_d[ln][8*off +: 8] = r_data_i[8*i +: 8];
        be_d[ln][off]           = 1'b1;
      end
    end
  end

  // Word leaves with the bytes of the completing beat
  assign word_wdata_o = wdata_d;
  assign word_be_o    = be_d;
  assign word_addr_o  = VADDR_W'(issue_insn_i.vd) * VADDR_W'(VREG_WORDS) + seq_q;
  assign word_id_o    = issue_insn_i.id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q      <= '0;
      loaded_q   <= 1'b0;
      word_pnt_q <= '0;
      seq_q      <= '0;
      be_q       <= '0;
    end else if (take) begin
      rem_q <= rem - beat_bytes;
      if (last_beat) begin
        // Rest of the beat is dropped and the next instruction starts clean
        loaded_q   <= 1'b0;
        word_pnt_q <= '0;
        seq_q      <= '0;
        be_q       <= '0;
      end else if (push_o) begin
        loaded_q   <= 1'b1;
        word_pnt_q <= '0;
        seq_q      <= seq_q + 1'b1;
        be_q       <= '0;
      end else begin
        loaded_q   <= 1'b1;
        word_pnt_q <= WPNT_W'(word_fill);
        be_q       <= be_d;
      end
    end
  end

  // Word payload
  always_ff @(posedge clk_i) begin
    if (take) begin
      wdata_q <= wdata_d;
    end
  end

  // Issuing instruction stays in place until its last beat
  assert property (@(posedge clk_i) disable iff (!rst_ni) loaded_q |-> issue_valid_i)
    else $error("issuing instruction withdrawn before its last beat");

endmodule

`default_nettype wire

// File: logic/vldu_insn_queue.sv
/*
 * Load instruction queue with accept, issue and commit pointers
 * Tracks running ids against the sequencer's running vector
 */
`timescale 1ns/1ns
`default_nettype none

module vldu_insn_queue import vldu_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Sequencer side
  input  logic                insn_valid_i,
  input  vldu_insn_t          insn_i,
  output logic                insn_ready_o,
  input  logic [NR_VINSN-1:0] vinsn_running_i,
  // Issue phase, toward the packer
  output vldu_insn_t          issue_insn_o,
  output logic                issue_valid_o,
  input  logic                issue_done_i,
  // Commit phase, toward the writeback
  output vldu_insn_t          commit_insn_o,
  output logic                commit_valid_o,
  input  logic                commit_done_i
);

  localparam int unsigned PNT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  vldu_insn_t [DEPTH-1:0] insn_q;
  logic [PNT_W-1:0]       accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Entries waiting for issue and entries waiting for commit
  logic [CNT_W-1:0]       issue_cnt_q, commit_cnt_q;
  logic [NR_VINSN-1:0]    running_d, running_q;
  logic                   queue_full;
  logic                   accept;

  // Circular pointer step
  function automatic logic [PNT_W-1:0] bump(input logic [PNT_W-1:0] pnt);
    return (pnt == PNT_W'(DEPTH - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // An entry is free only once its results are committed
  assign queue_full   = (commit_cnt_q == CNT_W'(DEPTH));
  assign insn_ready_o = !queue_full && !running_q[insn_i.id];
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue_insn_o   = insn_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign commit_insn_o  = insn_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  // Ids drop out when the sequencer clears them
  always_comb begin
    running_d = running_q & vinsn_running_i;
    if (accept) begin
      running_d[insn_i.id] = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Pointers and counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      running_q    <= '0;
    end else begin
      running_q <= running_d;
      if (accept) begin
        accept_pnt_q <= bump(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= bump(issue_pnt_q);
      end
      if (commit_done_i) begin
        commit_pnt_q <= bump(commit_pnt_q);
      end
      // Accept and retire may land on the same edge
      issue_cnt_q  <= issue_cnt_q + CNT_W'(accept) - CNT_W'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CNT_W'(accept) - CNT_W'(commit_done_i);
    end
  end

  // Instruction storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_i;
    end
  end

  // Packer only finishes an instruction it was handed
  assert property (@(posedge clk_i) disable iff (!rst_ni) issue_done_i |-> issue_valid_o)
    else $error("issue_done_i without an issuing instruction");

endmodule

`default_nettype wire

// File: logic/vldu_pkg.sv
/*
 * Shared parameters of the vector load unit
 * Element-width enum, instruction type and byte shuffle functions
 */
`default_nettype none

package vldu_pkg;

  // Default lane count, overridden by the top level
  localparam int unsigned NR_LANES     = 4;
  // Bytes per lane word and per memory read beat
  localparam int unsigned ELEN_BYTES   = 8;
  localparam int unsigned BEAT_BYTES   = 8;
  // Instruction ids
  localparam int unsigned NR_VINSN     = 8;
  localparam int unsigned VID_W        = 3;
  // Element count and lane word addressing
  localparam int unsigned VL_W         = 8;
  localparam int unsigned VREG_WORDS   = 8;
  localparam int unsigned VADDR_W      = 8;
  // Byte count of one instruction, vl shifted by up to 3
  localparam int unsigned INSN_BYTES_W = VL_W + 3;

  // Element width, value is log2 of the element bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  typedef struct packed {
    logic [VID_W-1:0] id;
    logic [4:0]       vd;
    logic [VL_W-1:0]  vl;
    vsew_e            vsew;
  } vldu_insn_t;

  // Total bytes moved by one instruction
  function automatic logic [INSN_BYTES_W-1:0] insn_bytes(input vldu_insn_t insn);
    return INSN_BYTES_W'(insn.vl) << insn.vsew;
  endfunction

  // Lane holding sequential byte b, elements spread round robin
  function automatic int unsigned shuffle_lane(input int unsigned b, input vsew_e s,
                                               input int unsigned lanes);
    int unsigned e;
    e = b >> s;
    return e % lanes;
  endfunction

  // Byte offset of sequential byte b inside its lane word
  function automatic int unsigned shuffle_offset(input int unsigned b, input vsew_e s,
                                                 input int unsigned lanes);
    int unsigned e;
    int unsigned k;
    e = b >> s;
    k = b - (e << s);
    return ((e / lanes) << s) + k;
  endfunction

endpackage

`default_nettype wire

// File: logic/vldu_writeback.sv
/*
 * Result queue toward the lanes with per-lane request/grant
 * Commit byte accounting and completion report
 */
`timescale 1ns/1ns
`default_nettype none

module vldu_writeback import vldu_pkg::*; #(
  parameter int unsigned NR_LANES = vldu_pkg::NR_LANES,
  parameter int unsigned DEPTH    = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Packer side
  input  logic                                  push_i,
  input  logic [NR_LANES-1:0][ELEN_BYTES*8-1:0] word_wdata_i,
  input  logic [NR_LANES-1:0][ELEN_BYTES-1:0]   word_be_i,
  input  logic [VADDR_W-1:0]                    word_addr_i,
  input  logic [VID_W-1:0]                      word_id_i,
  output logic                                  full_o,
  // Instruction in commit phase
  input  vldu_insn_t                            commit_insn_i,
  input  logic                                  commit_valid_i,
  output logic                                  commit_done_o,
  // Lane write ports
  output logic [NR_LANES-1:0]                   lane_req_o,
  output logic [NR_LANES-1:0][VADDR_W-1:0]      lane_addr_o,
  output logic [NR_LANES-1:0][VID_W-1:0]        lane_id_o,
  output logic [NR_LANES-1:0][ELEN_BYTES*8-1:0] lane_wdata_o,
  output logic [NR_LANES-1:0][ELEN_BYTES-1:0]   lane_be_o,
  input  logic [NR_LANES-1:0]                   lane_gnt_i,
  // Completion
  output logic                                  done_valid_o,
  output logic [VID_W-1:0]                      done_id_o
);

  localparam int unsigned WORD_BYTES = NR_LANES * ELEN_BYTES;
  localparam int unsigned PNT_W      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W      = $clog2(DEPTH + 1);

  logic [DEPTH-1:0][NR_LANES-1:0][ELEN_BYTES*8-1:0] wdata_q;
  logic [DEPTH-1:0][NR_LANES-1:0][ELEN_BYTES-1:0]   be_q;
  logic [DEPTH-1:0][VADDR_W-1:0]                    addr_q;
  logic [DEPTH-1:0][VID_W-1:0]                      id_q;
  // One pending bit per lane per entry
  logic [DEPTH-1:0][NR_LANES-1:0]                   lane_vld_q;
  logic [PNT_W-1:0]        wr_pnt_q, rd_pnt_q;
  logic [CNT_W-1:0]        cnt_q;
  logic [INSN_BYTES_W-1:0] commit_bytes_q, commit_bytes;
  logic                    commit_loaded_q;
  logic                    pop;
  logic                    last_pop;

  assign full_o = (cnt_q == CNT_W'(DEPTH));

  // Entry leaves once every lane took its word
  assign pop          = (cnt_q != '0) && (lane_vld_q[rd_pnt_q] == '0);
  assign commit_bytes = commit_loaded_q ? commit_bytes_q : insn_bytes(commit_insn_i);
  assign last_pop     = pop && commit_valid_i && (commit_bytes <= INSN_BYTES_W'(WORD_BYTES));

  assign commit_done_o = last_pop;
  assign done_valid_o  = last_pop;
  assign done_id_o     = commit_insn_i.id;

  // Head entry fans out to all lanes
  always_comb begin
    for (int unsigned l = 0; l < NR_LANES; l++) begin
      lane_req_o[l]   = lane_vld_q[rd_pnt_q][l];
      lane_addr_o[l]  = addr_q[rd_pnt_q];
      lane_id_o[l]    = id_q[rd_pnt_q];
      lane_wdata_o[l] = wdata_q[rd_pnt_q][l];
      lane_be_o[l]    = be_q[rd_pnt_q][l];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_vld_q      <= '0;
      wr_pnt_q        <= '0;
      rd_pnt_q        <= '0;
      cnt_q           <= '0;
      commit_bytes_q  <= '0;
      commit_loaded_q <= 1'b0;
    end else begin
      // A grant retires that lane's word
      for (int unsigned l = 0; l < NR_LANES; l++) begin
        if (lane_req_o[l] && lane_gnt_i[l]) begin
          lane_vld_q[rd_pnt_q][l] <= 1'b0;
        end
      end
      if (push_i) begin
        lane_vld_q[wr_pnt_q] <= '1;
        wr_pnt_q <= (wr_pnt_q == PNT_W'(DEPTH - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= (rd_pnt_q == PNT_W'(DEPTH - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push_i) - CNT_W'(pop);
      // Commit accounting, one full word per pop except the tail
      if (pop && commit_valid_i) begin
        commit_loaded_q <= !last_pop;
        commit_bytes_q  <= commit_bytes - INSN_BYTES_W'(WORD_BYTES);
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      wdata_q[wr_pnt_q] <= word_wdata_i;
      be_q[wr_pnt_q]    <= word_be_i;
      addr_q[wr_pnt_q]  <= word_addr_i;
      id_q[wr_pnt_q]    <= word_id_i;
    end
  end

  // Lanes grant only pending requests
  assert property (@(posedge clk_i) disable iff (!rst_ni) (lane_gnt_i & ~lane_req_o) == '0)
    else $error("lane grant without a request");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the vector load unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vldu -f vldu.f -o sim_vldu
./obj_dir/sim_vldu | tee sim.log

# Result is decided by the pass line in the log
grep -q "^=== PASS ===$" sim.log
echo "Simulation passed"

// File: verif/tb_vldu.sv
/*
 * Directed testbench for the vector load unit
 * Memory beat driver, lane responders, completion monitor
 * Reference model of the byte shuffle and lane addressing
 */
`timescale 1ns/1ns
`default_nettype none

module tb_vldu
  import vldu_pkg::*;
();

  localparam int LANES      = 4;
  localparam int WORD_BYTES = LANES * ELEN_BYTES;
  localparam int LOG_DEPTH  = 64;
  // Lane grant patterns
  localparam int GNT_ALWAYS = 0;
  localparam int GNT_RANDOM = 1;
  localparam int GNT_HOLD   = 2;

  logic                               clk_i = 1'b0;
  logic                               rst_ni;
  logic                               insn_valid_i;
  vldu_insn_t                         insn_i;
  logic                               insn_ready_o;
  logic [NR_VINSN-1:0]                vinsn_running_i;
  logic                               r_valid_i;
  logic [63:0]                        r_data_i;
  logic                               r_ready_o;
  logic [LANES-1:0]                   lane_req_o;
  logic [LANES-1:0][VADDR_W-1:0]      lane_addr_o;
  logic [LANES-1:0][VID_W-1:0]        lane_id_o;
  logic [LANES-1:0][63:0]             lane_wdata_o;
  logic [LANES-1:0][7:0]              lane_be_o;
  logic [LANES-1:0]                   lane_gnt_i;
  logic                               done_valid_o;
  logic [VID_W-1:0]                   done_id_o;

  // Pending memory beats, front is on the bus
  logic [63:0] beat_q [$];
  int          beats_taken;
  int          byte_no;
  integer      seed;
  int          gnt_mode [LANES];
  int          errors;
  int          checks;

  // Expected and received lane words, counted over the whole run
  logic [VADDR_W-1:0] exp_addr  [LANES][LOG_DEPTH];
  logic [VID_W-1:0]   exp_id    [LANES][LOG_DEPTH];
  logic [63:0]        exp_wdata [LANES][LOG_DEPTH];
  logic [7:0]         exp_be    [LANES][LOG_DEPTH];
  int                 exp_cnt   [LANES];
  logic [VADDR_W-1:0] rec_addr  [LANES][LOG_DEPTH];
  logic [VID_W-1:0]   rec_id    [LANES][LOG_DEPTH];
  logic [63:0]        rec_wdata [LANES][LOG_DEPTH];
  logic [7:0]         rec_be    [LANES][LOG_DEPTH];
  int                 rec_cnt   [LANES];
  int                 checked   [LANES];
  // Completion ids, expected and seen
  logic [VID_W-1:0]   exp_done  [LOG_DEPTH];
  logic [VID_W-1:0]   done_log  [LOG_DEPTH];
  int                 exp_done_cnt;
  int                 done_cnt;
  int                 done_checked;

  always #50 clk_i = ~clk_i;

  vldu #(.NR_LANES(LANES), .INSN_DEPTH(4), .RESQ_DEPTH(2)) uut (
    .clk_i, .rst_ni,
    .insn_valid_i, .insn_i, .insn_ready_o, .vinsn_running_i,
    .r_valid_i, .r_data_i, .r_ready_o,
    .lane_req_o, .lane_addr_o, .lane_id_o, .lane_wdata_o, .lane_be_o, .lane_gnt_i,
    .done_valid_o, .done_id_o
  );

  //////////////////////////////////////////////////
  // Memory, lanes and completion monitor
  //////////////////////////////////////////////////

  // Beat seen with r_ready_o high is consumed on the next rising edge
  initial begin : mem_driver
    logic taken;
    taken       = 1'b0;
    beats_taken = 0;
    r_valid_i   = 1'b0;
    r_data_i    = '0;
    forever begin
      @(negedge clk_i);
      if (taken) begin
        void'(beat_q.pop_front());
        beats_taken++;
      end
      r_valid_i = (beat_q.size() != 0);
      r_data_i  = r_valid_i ? beat_q[0] : 64'd0;
      taken     = r_valid_i && r_ready_o;
    end
  end

  // Grant per lane, logged as the lane accepts it
  initial begin : lane_responder
    int     l;
    integer rnd;
    seed       = 32'h9a03;
    lane_gnt_i = '0;
    for (l = 0; l < LANES; l++) begin
      rec_cnt[l] = 0;
    end
    forever begin
      @(negedge clk_i);
      for (l = 0; l < LANES; l++) begin
        rnd = $random(seed);
        case (gnt_mode[l])
          GNT_ALWAYS: lane_gnt_i[l] = lane_req_o[l];
          GNT_RANDOM: lane_gnt_i[l] = lane_req_o[l] & rnd[0];
          default:    lane_gnt_i[l] = 1'b0;
        endcase
        if (lane_gnt_i[l] && rec_cnt[l] < LOG_DEPTH) begin
          rec_addr[l][rec_cnt[l]]  = lane_addr_o[l];
          rec_id[l][rec_cnt[l]]    = lane_id_o[l];
          rec_wdata[l][rec_cnt[l]] = lane_wdata_o[l];
          rec_be[l][rec_cnt[l]]    = lane_be_o[l];
          rec_cnt[l]++;
        end
      end
    end
  end

  initial begin : done_monitor
    done_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (done_valid_o && done_cnt < LOG_DEPTH) begin
        done_log[done_cnt] = done_id_o;
        done_cnt++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic vldu_insn_t make_insn(input logic [2:0] id, input logic [4:0] vd,
                                          input logic [7:0] vl, input vsew_e vsew);
    vldu_insn_t insn;
    insn.id   = id;
    insn.vd   = vd;
    insn.vl   = vl;
    insn.vsew = vsew;
    return insn;
  endfunction

  // Distinct value for every byte of a 256 byte window
  function automatic logic [7:0] fill_byte(input int n);
    return 8'(n * 29 + 60 + (n >> 8));
  endfunction

  function automatic logic [63:0] byte_mask(input logic [7:0] be);
    logic [63:0] m;
    for (int i = 0; i < 8; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  task automatic set_grants(input int mode);
    for (int l = 0; l < LANES; l++) begin
      gnt_mode[l] = mode;
    end
  endtask

  // Beats of one instruction plus the lane words it must produce
  task automatic queue_load(input vldu_insn_t insn);
    int          nbytes, nbeats, nwords;
    int          b, i, w, p, e, k, ln, off, l;
    logic [63:0] beat;
    logic [7:0]  data [2048];
    logic [63:0] wd [LANES];
    logic [7:0]  be [LANES];
    nbytes = int'(insn.vl) << int'(insn.vsew);
    nbeats = (nbytes + 7) / 8;
    for (b = 0; b < nbeats; b++) begin
      for (i = 0; i < 8; i++) begin
        beat[8*i +: 8] = fill_byte(byte_no);
        data[8*b + i]  = beat[8*i +: 8];
        byte_no++;
      end
      beat_q.push_back(beat);
    end
    nwords = (nbytes + WORD_BYTES - 1) / WORD_BYTES;
    for (w = 0; w < nwords; w++) begin
      for (l = 0; l < LANES; l++) begin
        wd[l] = '0;
        be[l] = '0;
      end
      // Element e goes to lane e mod lanes, row e / lanes
      for (p = 0; p < WORD_BYTES; p++) begin
        if (w * WORD_BYTES + p < nbytes) begin
          e   = p >> int'(insn.vsew);
          k   = p - (e << int'(insn.vsew));
          ln  = e % LANES;
          off = ((e / LANES) << int'(insn.vsew)) + k;
          wd[ln][8*off +: 8] = data[w * WORD_BYTES + p];
          be[ln][off]        = 1'b1;
        end
      end
      for (l = 0; l < LANES; l++) begin
        exp_addr[l][exp_cnt[l]]  = VADDR_W'(int'(insn.vd) * int'(VREG_WORDS) + w);
        exp_id[l][exp_cnt[l]]    = insn.id;
        exp_wdata[l][exp_cnt[l]] = wd[l];
        exp_be[l][exp_cnt[l]]    = be[l];
        exp_cnt[l]++;
      end
    end
    exp_done[exp_done_cnt] = insn.id;
    exp_done_cnt++;
  endtask

  task automatic present_insn(input vldu_insn_t insn);
    @(negedge clk_i);
    insn_valid_i = 1'b1;
    insn_i       = insn;
  endtask

  // Valid stays up until ready is seen
  task automatic await_accept(input int max_cycles);
    int n;
    bit ok;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < max_cycles) begin
      #1;
      ok = insn_ready_o;
      n++;
      @(negedge clk_i);
    end
    insn_valid_i = 1'b0;
    if (!ok) begin
      $display("Instruction id %0d was not accepted within %0d cycles", insn_i.id, max_cycles);
      errors++;
    end
  endtask

  task automatic send_insn(input vldu_insn_t insn);
    present_insn(insn);
    await_accept(100);
  endtask

  // All expected completions, then a few idle cycles to catch extra pulses
  task automatic wait_done(input int max_cycles);
    int n;
    n = 0;
    while (done_cnt < exp_done_cnt && n < max_cycles) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (done_cnt < exp_done_cnt) begin
      $display("Timed out with %0d of %0d completions", done_cnt, exp_done_cnt);
      errors++;
    end
    repeat (4) @(negedge clk_i);
  endtask

  task automatic check_results();
    int l;
    int n;
    for (l = 0; l < LANES; l++) begin
      check_val($sformatf("lane %0d word count", l), 64'(rec_cnt[l]), 64'(exp_cnt[l]));
      for (n = checked[l]; n < exp_cnt[l] && n < rec_cnt[l]; n++) begin
        check_val($sformatf("lane_addr_o[%0d]", l), 64'(rec_addr[l][n]), 64'(exp_addr[l][n]));
        check_val($sformatf("lane_id_o[%0d]", l), 64'(rec_id[l][n]), 64'(exp_id[l][n]));
        check_val($sformatf("lane_be_o[%0d]", l), 64'(rec_be[l][n]), 64'(exp_be[l][n]));
        // Bytes outside the enables carry no data
        check_val($sformatf("lane_wdata_o[%0d]", l),
                  rec_wdata[l][n] & byte_mask(exp_be[l][n]), exp_wdata[l][n]);
      end
      checked[l] = exp_cnt[l];
    end
    check_val("done_valid_o count", 64'(done_cnt), 64'(exp_done_cnt));
    for (n = done_checked; n < exp_done_cnt && n < done_cnt; n++) begin
      check_val("done_id_o", 64'(done_log[n]), 64'(exp_done[n]));
    end
    done_checked = exp_done_cnt;
    check_val("beats left", 64'(beat_q.size()), 64'd0);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_state();
    @(negedge clk_i);
    #1;
    check_val("insn_ready_o", 64'(insn_ready_o), 64'd1);
    check_val("r_ready_o", 64'(r_ready_o), 64'd0);
    check_val("lane_req_o", 64'(lane_req_o), 64'd0);
    check_val("done_valid_o", 64'(done_valid_o), 64'd0);
  endtask

  // 32 bytes fill exactly one VRF word
  task automatic full_ew32_load();
    vldu_insn_t insn;
    insn = make_insn(3'd1, 5'd3, 8'd8, EW32);
    set_grants(GNT_ALWAYS);
    queue_load(insn);
    send_insn(insn);
    wait_done(200);
    check_results();
  endtask

  // Tail of the short beat is dropped before the next load
  task automatic short_ew8_load();
    vldu_insn_t first, second;
    first  = make_insn(3'd2, 5'd5, 8'd5, EW8);
    second = make_insn(3'd3, 5'd6, 8'd8, EW8);
    queue_load(first);
    queue_load(second);
    send_insn(first);
    send_insn(second);
    wait_done(200);
    check_results();
  endtask

  task automatic back_to_back_loads();
    vldu_insn_t insn [4];
    vldu_insn_t fifth;
    int         base;
    int         n;
    base    = done_cnt;
    insn[0] = make_insn(3'd4, 5'd10, 8'd40, EW8);
    insn[1] = make_insn(3'd5, 5'd11, 8'd12, EW16);
    insn[2] = make_insn(3'd6, 5'd12, 8'd16, EW32);
    insn[3] = make_insn(3'd7, 5'd13, 8'd6, EW64);
    fifth   = make_insn(3'd0, 5'd14, 8'd3, EW16);
    // Lanes hold off so nothing completes while the queue fills
    set_grants(GNT_HOLD);
    for (n = 0; n < 4; n++) begin
      queue_load(insn[n]);
      send_insn(insn[n]);
    end
    queue_load(fifth);
    present_insn(fifth);
    for (n = 0; n < 10; n++) begin
      #1;
      check_val("insn_ready_o", 64'(insn_ready_o), 64'd0);
      @(negedge clk_i);
    end
    set_grants(GNT_RANDOM);
    await_accept(400);
    check_val("completions before fifth accept", 64'(done_cnt > base), 64'd1);
    wait_done(800);
    check_results();
  endtask

  task automatic lane_backpressure();
    vldu_insn_t insn;
    int         base;
    int         n;
    insn = make_insn(3'd1, 5'd2, 8'd32, EW32);
    set_grants(GNT_ALWAYS);
    gnt_mode[2] = GNT_HOLD;
    base = beats_taken;
    queue_load(insn);
    send_insn(insn);
    n = 0;
    while (beats_taken < base + 8 && n < 100) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (beats_taken < base + 8) begin
      $display("Timed out before two words were packed");
      errors++;
    end
    // Both result entries wait on lane 2
    for (n = 0; n < 12; n++) begin
      check_val("r_ready_o", 64'(r_ready_o), 64'd0);
      @(negedge clk_i);
      #1;
    end
    check_val("beats taken while stalled", 64'(beats_taken - base), 64'd8);
    gnt_mode[2] = GNT_ALWAYS;
    wait_done(400);
    check_results();
  endtask

  task automatic running_id_guard();
    vldu_insn_t first, second;
    int         n;
    first  = make_insn(3'd5, 5'd20, 8'd8, EW8);
    second = make_insn(3'd5, 5'd21, 8'd4, EW16);
    queue_load(first);
    queue_load(second);
    @(negedge clk_i);
    vinsn_running_i[5] = 1'b1;
    send_insn(first);
    present_insn(second);
    for (n = 0; n < 8; n++) begin
      #1;
      check_val("insn_ready_o", 64'(insn_ready_o), 64'd0);
      @(negedge clk_i);
    end
    vinsn_running_i = '0;
    await_accept(100);
    wait_done(300);
    check_results();
  endtask

  initial begin
    errors          = 0;
    checks          = 0;
    byte_no         = 0;
    exp_done_cnt    = 0;
    done_checked    = 0;
    rst_ni          = 1'b0;
    insn_valid_i    = 1'b0;
    insn_i          = '0;
    vinsn_running_i = '0;
    for (int l = 0; l < LANES; l++) begin
      exp_cnt[l]  = 0;
      checked[l]  = 0;
      gnt_mode[l] = GNT_ALWAYS;
    end
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    reset_state();
    full_ew32_load();
    short_ew8_load();
    back_to_back_loads();
    lane_backpressure();
    running_id_guard();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vldu.f
logic/vldu_pkg.sv
logic/vldu_insn_queue.sv
logic/vldu_beat_packer.sv
logic/vldu_writeback.sv
logic/vldu.sv
verif/tb_vldu.sv
